/* verilog/isaPkg.sv */
package isaPkg;

	typedef logic [31:0] wordT;    // Data, address or instruction
	typedef logic [4:0]  regAddrT;
	typedef logic [5:0]  opcodeT;
	typedef logic [5:0]  functT;

	// Primary opcodes
	localparam opcodeT OpRtype = 6'h00;
	localparam opcodeT OpJal   = 6'h03;
	localparam opcodeT OpBeq   = 6'h04;
	localparam opcodeT OpBne   = 6'h05;
	localparam opcodeT OpAddi  = 6'h08;
	localparam opcodeT OpAndi  = 6'h0c;
	localparam opcodeT OpOri   = 6'h0d;
	localparam opcodeT OpLui   = 6'h0f;
	localparam opcodeT OpLw    = 6'h23;
	localparam opcodeT OpSw    = 6'h2b;

	// Function codes under OpRtype
	localparam functT FnJr   = 6'h08;
	localparam functT FnAdd  = 6'h20;
	localparam functT FnSub  = 6'h22;
	localparam functT FnAnd  = 6'h24;
	localparam functT FnOr   = 6'h25;
	localparam functT FnSlt  = 6'h2a;
	localparam functT FnSltu = 6'h2b;

	// Register fields, 5 bits each
	localparam int RsLsb = 21;
	localparam int RtLsb = 16;
	localparam int RdLsb = 11;

	typedef enum logic [3:0] {
		AluAdd,
		AluSub,
		AluAnd,
		AluOr,
		AluSlt,
		AluSltu,
		AluAndi,
		AluOri,
		AluAddi    // Also load/store address
	} aluOpT;

endpackage

/* verilog/hazardPkg.sv */
package hazardPkg;

	// Counted in stages
	// Use time is how far past decode a source is first needed,
	// new time is how many stages remain until the result exists
	typedef logic [1:0] stageTimeT;

	// Hardwired zero that never produces a value
	localparam isaPkg::regAddrT ZeroReg = 5'd0;

	localparam isaPkg::regAddrT LinkReg = 5'd31;    // Written by jal

endpackage

/* verilog/regFile.sv */
`timescale 1ns/10ps

module regFile (
	input  logic            clk,
	input  logic            reset,
	input  isaPkg::regAddrT rdAddr1,
	input  isaPkg::regAddrT rdAddr2,
	output isaPkg::wordT    rdData1,
	output isaPkg::wordT    rdData2,
	input  logic            wrEn,
	input  isaPkg::regAddrT wrAddr,
	input  isaPkg::wordT    wrData
);
	import isaPkg::*;

	wordT regs [1:31];    // No storage behind register zero
	logic wrHit;

	assign wrHit = wrEn && (wrAddr != '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wrHit) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Same-cycle write passes straight to decode
	assign rdData1 = (rdAddr1 == '0) ? '0 :
		(wrHit && wrAddr == rdAddr1) ? wrData : regs[rdAddr1];
	assign rdData2 = (rdAddr2 == '0) ? '0 :
		(wrHit && wrAddr == rdAddr2) ? wrData : regs[rdAddr2];

endmodule

/* verilog/alu.sv */
`timescale 1ns/10ps

module alu (
	input  isaPkg::wordT  a,
	input  isaPkg::wordT  b,
	input  logic [15:0]   imm,
	input  isaPkg::aluOpT op,
	output isaPkg::wordT  result
);
	import isaPkg::*;

	wordT immZero;
	wordT immSign;

	assign immZero = {16'h0000, imm};      // andi, ori
	assign immSign = {{16{imm[15]}}, imm};

	// Sums wrap without an overflow trap
	always_comb begin
		case (op)
			AluAdd:  result = a + b;
			AluSub:  result = a - b;
			AluAnd:  result = a & b;
			AluOr:   result = a | b;
			AluSlt:  result = {31'd0, $signed(a) < $signed(b)};
			AluSltu: result = {31'd0, a < b};
			AluAndi: result = a & immZero;
			AluOri:  result = a | immZero;
			AluAddi: result = a + immSign;
			default: result = a + b;
		endcase
	end

endmodule

/* verilog/decodeUnit.sv */
`timescale 1ns/10ps

module decodeUnit (
	input  isaPkg::wordT         instr,
	input  isaPkg::wordT         pc,
	input  isaPkg::wordT         rsValue,
	input  isaPkg::wordT         rtValue,
	output isaPkg::regAddrT      rsUse,
	output isaPkg::regAddrT      rtUse,
	output hazardPkg::stageTimeT rsUseTime,
	output hazardPkg::stageTimeT rtUseTime,
	output isaPkg::regAddrT      newReg,
	output hazardPkg::stageTimeT newTime,
	output isaPkg::wordT         newValue,
	output isaPkg::aluOpT        aluOp,
	output logic                 memRead,
	output logic                 memWrite,
	output logic                 jumpEn,
	output isaPkg::wordT         jumpTarget
);
	import isaPkg::*;
	import hazardPkg::*;

	opcodeT  opcode;
	functT   funct;
	regAddrT rs;
	regAddrT rt;
	regAddrT rd;
	wordT    slotPc;    // Delay-slot address
	aluOpT   rtypeOp;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];
	assign rs     = instr[RsLsb +: 5];
	assign rt     = instr[RtLsb +: 5];
	assign rd     = instr[RdLsb +: 5];
	assign slotPc = pc + 32'd4;

	always_comb begin
		case (funct)
			FnSub:   rtypeOp = AluSub;
			FnAnd:   rtypeOp = AluAnd;
			FnOr:    rtypeOp = AluOr;
			FnSlt:   rtypeOp = AluSlt;
			FnSltu:  rtypeOp = AluSltu;
			default: rtypeOp = AluAdd;
		endcase
	end

	always_comb begin
		// Anything unrecognized falls through as a nop
		rsUse      = ZeroReg;
		rtUse      = ZeroReg;
		rsUseTime  = 2'd0;
		rtUseTime  = 2'd0;
		newReg     = ZeroReg;
		newTime    = 2'd0;
		newValue   = '0;
		aluOp      = AluAdd;
		memRead    = 1'b0;
		memWrite   = 1'b0;
		jumpEn     = 1'b0;
		jumpTarget = slotPc + {{14{instr[15]}}, instr[15:0], 2'b00};
		case (opcode)
			OpRtype: begin
				if (funct == FnJr) begin
					rsUse      = rs;    // Needed right here in decode
					jumpEn     = 1'b1;
					jumpTarget = rsValue;
				end else if (funct inside {FnAdd, FnSub, FnAnd, FnOr, FnSlt, FnSltu}) begin
					rsUse     = rs;
					rtUse     = rt;
					rsUseTime = 2'd1;
					rtUseTime = 2'd1;
					newReg    = rd;
					newTime   = 2'd1;
					aluOp     = rtypeOp;
				end
			end
			OpAddi, OpAndi, OpOri: begin
				rsUse     = rs;
				rsUseTime = 2'd1;
				newReg    = rt;
				newTime   = 2'd1;
				aluOp     = (opcode == OpAddi) ? AluAddi : (opcode == OpAndi) ? AluAndi : AluOri;
			end
			OpLui: begin
				newReg   = rt;
				newValue = {instr[15:0], 16'h0000};    // Ready immediately
			end
			OpLw: begin
				rsUse     = rs;
				rsUseTime = 2'd1;
				newReg    = rt;
				newTime   = 2'd2;
				aluOp     = AluAddi;
				memRead   = 1'b1;
			end
			OpSw: begin
				rsUse     = rs;
				rtUse     = rt;
				rsUseTime = 2'd1;
				rtUseTime = 2'd2;    // Store data waits until memory
				aluOp     = AluAddi;
				memWrite  = 1'b1;
			end
			OpBeq, OpBne: begin
				rsUse  = rs;
				rtUse  = rt;
				jumpEn = (opcode == OpBeq) ? (rsValue == rtValue) : (rsValue != rtValue);
			end
			OpJal: begin
				newReg     = LinkReg;
				newValue   = pc + 32'd8;
				jumpEn     = 1'b1;
				jumpTarget = {slotPc[31:28], instr[25:0], 2'b00};
			end
			default: ;
		endcase
	end

endmodule

/* verilog/hazardUnit.sv */
`timescale 1ns/10ps

module hazardUnit (
	input  isaPkg::regAddrT      rsD,
	input  isaPkg::regAddrT      rtD,
	input  hazardPkg::stageTimeT rsUseTime,
	input  hazardPkg::stageTimeT rtUseTime,
	input  isaPkg::wordT         rfRs,
	input  isaPkg::wordT         rfRt,
	input  isaPkg::regAddrT      rsE,
	input  isaPkg::regAddrT      rtE,
	input  isaPkg::wordT         rsValE,
	input  isaPkg::wordT         rtValE,
	input  isaPkg::regAddrT      rtM,
	input  isaPkg::wordT         rtValM,
	input  isaPkg::regAddrT      newRegE,
	input  isaPkg::regAddrT      newRegM,
	input  isaPkg::regAddrT      newRegW,
	input  hazardPkg::stageTimeT newTimeE,
	input  hazardPkg::stageTimeT newTimeM,
	input  hazardPkg::stageTimeT newTimeW,
	input  isaPkg::wordT         newValE,
	input  isaPkg::wordT         newValM,
	input  isaPkg::wordT         newValW,
	output logic                 stall,
	output isaPkg::wordT         fwdRsD,
	output isaPkg::wordT         fwdRtD,
	output isaPkg::wordT         fwdRsE,
	output isaPkg::wordT         fwdRtE,
	output isaPkg::wordT         fwdRtM
);
	import isaPkg::*;
	import hazardPkg::*;

	// Youngest matching producer is not ready by the time it is used
	function automatic logic tooLate(regAddrT src, stageTimeT useTime);
		logic late;
		late = 1'b0;
		if (src != ZeroReg) begin
			if (src == newRegE)
				late = newTimeE > useTime;
			else if (src == newRegM)
				late = newTimeM > useTime;
			else if (src == newRegW)
				late = newTimeW > useTime;
		end
		return late;
	endfunction

	// Producer mask bits are E, M, W; a value still pending leaves the older one
	function automatic wordT pick(regAddrT src, wordT older, logic [2:0] seen);
		wordT value;
		value = older;
		if (src != ZeroReg) begin
			if (seen[2] && src == newRegE)
				value = (newTimeE == 2'd0) ? newValE : older;
			else if (seen[1] && src == newRegM)
				value = (newTimeM == 2'd0) ? newValM : older;
			else if (seen[0] && src == newRegW)
				value = (newTimeW == 2'd0) ? newValW : older;
		end
		return value;
	endfunction

	always_comb begin
		stall  = tooLate(rsD, rsUseTime) || tooLate(rtD, rtUseTime);
		fwdRsD = pick(rsD, rfRs, 3'b111);
		fwdRtD = pick(rtD, rfRt, 3'b111);
		fwdRsE = pick(rsE, rsValE, 3'b011);    // Only stages behind execute
		fwdRtE = pick(rtE, rtValE, 3'b011);
		fwdRtM = pick(rtM, rtValM, 3'b001);
	end

endmodule

/* verilog/mipsCore.sv */
`timescale 1ns/10ps

module mipsCore #(
	parameter isaPkg::wordT ResetPc = 32'h0000_3000
) (
	input  logic            clk,
	input  logic            reset,
	output isaPkg::wordT    instAddr,
	input  isaPkg::wordT    instData,
	output isaPkg::wordT    dataAddr,
	output isaPkg::wordT    dataWdata,
	output logic            dataWe,
	input  isaPkg::wordT    dataRdata,
	output logic            regWe,
	output isaPkg::regAddrT regAddr,
	output isaPkg::wordT    regWdata,
	output isaPkg::wordT    wbPc
);
	import isaPkg::*;
	import hazardPkg::*;

	// Pending times count down in each register after execute
	function automatic stageTimeT tick(stageTimeT t);
		return (t != 2'd0) ? t - 2'd1 : t;
	endfunction

	wordT pcF, pcD, instrD, jumpTarget, rfRs, rfRt, fwdRsD, fwdRtD, newValD;
	regAddrT rsD, rtD, newRegD;
	stageTimeT rsUseTime, rtUseTime, newTimeD;
	aluOpT aluOpD, aluOpE;
	logic stall, jumpEn, memReadD, memWriteD;

	wordT pcE, rsValE, rtValE, newValE, fwdRsE, fwdRtE, aluResult;
	regAddrT rsE, rtE, newRegE;
	stageTimeT newTimeE;
	logic [15:0] immE;
	logic memReadE, memWriteE;

	wordT pcM, rtValM, newValM, fwdRtM, pcW, newValW;
	regAddrT rtM, newRegM, newRegW;
	stageTimeT newTimeM, newTimeW;
	logic memReadM, memWriteM;

	////////////////////
	// Fetch and decode
	always_ff @(posedge clk) begin
		if (reset) begin
			pcF    <= ResetPc;
			instrD <= '0;    // Decodes as a nop
		end else if (!stall) begin
			pcF    <= jumpEn ? jumpTarget : pcF + 32'd4;    // Redirect lands after the slot
			instrD <= instData;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall)
			pcD <= pcF;
	end

	assign instAddr = pcF;

	decodeUnit u_decodeUnit (
		.instr(instrD), .pc(pcD), .rsValue(fwdRsD), .rtValue(fwdRtD),
		.rsUse(rsD), .rtUse(rtD), .rsUseTime(rsUseTime), .rtUseTime(rtUseTime),
		.newReg(newRegD), .newTime(newTimeD), .newValue(newValD),
		.aluOp(aluOpD), .memRead(memReadD), .memWrite(memWriteD),
		.jumpEn(jumpEn), .jumpTarget(jumpTarget)
	);

	hazardUnit u_hazardUnit (
		.rsD(rsD), .rtD(rtD), .rsUseTime(rsUseTime), .rtUseTime(rtUseTime),
		.rfRs(rfRs), .rfRt(rfRt),
		.rsE(rsE), .rtE(rtE), .rsValE(rsValE), .rtValE(rtValE),
		.rtM(rtM), .rtValM(rtValM),
		.newRegE(newRegE), .newRegM(newRegM), .newRegW(newRegW),
		.newTimeE(newTimeE), .newTimeM(newTimeM), .newTimeW(newTimeW),
		.newValE(newValE), .newValM(newValM), .newValW(newValW),
		.stall(stall), .fwdRsD(fwdRsD), .fwdRtD(fwdRtD),
		.fwdRsE(fwdRsE), .fwdRtE(fwdRtE), .fwdRtM(fwdRtM)
	);

	////////////////////
	// Execute
	always_ff @(posedge clk) begin
		if (reset || stall) begin    // Bubble
			rsE       <= ZeroReg;
			rtE       <= ZeroReg;
			memReadE  <= 1'b0;
			memWriteE <= 1'b0;
			newRegE   <= ZeroReg;
			newTimeE  <= 2'd0;
		end else begin
			rsE       <= rsD;
			rtE       <= rtD;
			memReadE  <= memReadD;
			memWriteE <= memWriteD;
			newRegE   <= newRegD;
			newTimeE  <= newTimeD;
		end
	end

	always_ff @(posedge clk) begin
		pcE     <= pcD;
		rsValE  <= fwdRsD;
		rtValE  <= fwdRtD;
		immE    <= instrD[15:0];
		aluOpE  <= aluOpD;
		newValE <= newValD;
	end

	alu u_alu (.a(fwdRsE), .b(fwdRtE), .imm(immE), .op(aluOpE), .result(aluResult));

	////////////////////
	// Memory
	always_ff @(posedge clk) begin
		if (reset) begin
			rtM       <= ZeroReg;
			memReadM  <= 1'b0;
			memWriteM <= 1'b0;
			newRegM   <= ZeroReg;
			newTimeM  <= 2'd0;
		end else begin
			rtM       <= rtE;
			memReadM  <= memReadE;
			memWriteM <= memWriteE;
			newRegM   <= newRegE;
			newTimeM  <= tick(newTimeE);
		end
	end

	// lui and jal already hold their value and the rest take the ALU result
	always_ff @(posedge clk) begin
		pcM     <= pcE;
		rtValM  <= fwdRtE;
		newValM <= (newTimeE != 2'd0 || memWriteE) ? aluResult : newValE;
	end

	assign dataAddr  = newValM;
	assign dataWdata = fwdRtM;
	assign dataWe    = memWriteM;

	////////////////////
	// Writeback
	always_ff @(posedge clk) begin
		if (reset) begin
			newRegW  <= ZeroReg;
			newTimeW <= 2'd0;
		end else begin
			newRegW  <= newRegM;
			newTimeW <= tick(newTimeM);
		end
	end

	always_ff @(posedge clk) begin
		pcW     <= pcM;
		newValW <= memReadM ? dataRdata : newValM;
	end

	assign regWe    = (newRegW != ZeroReg);
	assign regAddr  = newRegW;
	assign regWdata = newValW;
	assign wbPc     = pcW;

	regFile u_regFile (
		.clk(clk), .reset(reset),
		.rdAddr1(rsD), .rdAddr2(rtD), .rdData1(rfRs), .rdData2(rfRt),
		.wrEn(regWe), .wrAddr(newRegW), .wrData(newValW)
	);

	pcAligned: assert property (@(posedge clk) disable iff (reset) pcF[1:0] == 2'b00);

	noStoreOnLoad: assert property (@(posedge clk) disable iff (reset) !(dataWe && memReadM));

	// Longest stall is a load feeding a branch
	stallBounded: assert property (@(posedge clk) disable iff (reset)
		stall && $past(stall) |=> !stall);

endmodule

/* tests/mipsCoreTb.sv */
`timescale 1ns/10ps

module mipsCoreTb;
	import isaPkg::*;

	localparam wordT ResetPc = 32'h0000_3000;
	localparam int CycleLimit = 600;    // Up to 20 instructions per test with stalls and drain
	localparam int DrainCycles = 8;

	logic clk;
	logic reset;
	wordT instAddr, instData, instOffset;
	wordT dataAddr, dataWdata, dataRdata;
	logic dataWe;
	logic regWe;
	regAddrT regAddr;
	wordT regWdata, wbPc;

	wordT instMem [0:63];
	wordT dataMem [0:63];
	int placeIdx;
	int cycleCount;

	regAddrT traceReg[$];
	regAddrT expReg[$];
	wordT traceVal[$], tracePc[$], expVal[$], expPc[$];
	wordT storeAddr[$], storeData[$];

	mipsCore #(.ResetPc(ResetPc)) u_mipsCore (
		.clk(clk), .reset(reset),
		.instAddr(instAddr), .instData(instData),
		.dataAddr(dataAddr), .dataWdata(dataWdata), .dataWe(dataWe), .dataRdata(dataRdata),
		.regWe(regWe), .regAddr(regAddr), .regWdata(regWdata), .wbPc(wbPc)
	);

	always #20 clk = ~clk;

	////////////////////
	// Memory models
	assign instOffset = instAddr - ResetPc;
	assign instData   = (instOffset < 32'd256) ? instMem[instOffset[7:2]] : '0;    // Nops past the end
	assign dataRdata  = dataMem[dataAddr[7:2]];

	always @(posedge clk) begin
		if (dataWe === 1'b1)
			dataMem[dataAddr[7:2]] <= dataWdata;
	end

	// Retire and store trace sampled mid-cycle
	always @(negedge clk) begin
		if (reset === 1'b0 && regWe === 1'b1) begin
			traceReg.push_back(regAddr);
			traceVal.push_back(regWdata);
			tracePc.push_back(wbPc);
		end
		if (reset === 1'b0 && dataWe === 1'b1) begin
			storeAddr.push_back(dataAddr);
			storeData.push_back(dataWdata);
		end
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CycleLimit) begin
			$display("Timeout: the tests did not finish within %0d cycles", CycleLimit);
			$display("Simulation FAILED");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	////////////////////
	// Instruction encoding
	function automatic wordT rType(functT fn, regAddrT rd, regAddrT rs, regAddrT rt);
		return {OpRtype, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic wordT iType(opcodeT op, regAddrT rt, regAddrT rs, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic wordT jalInstr(wordT target);
		return {OpJal, target[27:2]};
	endfunction

	////////////////////
	// Helpers
	task automatic checkValue(input string name, input wordT expected, input wordT actual);
		if (actual !== expected) begin
			$display("Mismatch at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
			$display("Simulation FAILED");
			$fatal(1, "Stopped at the first error");
		end
	endtask

	task automatic clearMemories();
		int i;
		for (i = 0; i < 64; i++) begin
			instMem[i] = '0;
			dataMem[i] = 32'hC0DE_0000 | (i << 2);    // Low bits carry the byte address
		end
		placeIdx = 0;
	endtask

	task automatic holdReset();
		@(posedge clk);
		reset <= 1'b1;
		@(negedge clk);
		clearMemories();
		traceReg.delete();
		traceVal.delete();
		tracePc.delete();
		storeAddr.delete();
		storeData.delete();
		expReg.delete();
		expVal.delete();
		expPc.delete();
	endtask

	task automatic releaseReset();
		int i;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		checkValue("instAddr", ResetPc, instAddr);
		// First retire comes four edges after the first fetch
		for (i = 0; i < 4; i++) begin
			if (i > 0)
				@(negedge clk);
			checkValue("regWe", 1'b0, regWe);
			checkValue("dataWe", 1'b0, dataWe);
		end
	endtask

	task automatic placeInstr(input wordT w);
		instMem[placeIdx] = w;
		placeIdx++;
	endtask

	task automatic expectWrite(input regAddrT r, input wordT v, input int idx);
		expReg.push_back(r);
		expVal.push_back(v);
		expPc.push_back(ResetPc + idx * 4);
	endtask

	task automatic compareTrace();
		int i;
		while (traceReg.size() < expReg.size())
			@(posedge clk);
		repeat (DrainCycles) @(posedge clk);    // Anything retired by mistake shows up by now
		for (i = 0; i < expReg.size(); i++) begin
			checkValue($sformatf("regAddr[%0d]", i), expReg[i], traceReg[i]);
			checkValue($sformatf("regWdata[%0d]", i), expVal[i], traceVal[i]);
			checkValue($sformatf("wbPc[%0d]", i), expPc[i], tracePc[i]);
		end
		checkValue("writeback count", expReg.size(), traceReg.size());
	endtask

	////////////////////
	// Directed tests
	task automatic aluChain();
		wordT v [1:11];
		int i;
		holdReset();
		placeInstr(iType(OpOri, 1, 0, 16'h1234));
		placeInstr(iType(OpLui, 2, 0, 16'h8000));
		placeInstr(rType(FnAdd, 3, 1, 2));
		placeInstr(rType(FnSub, 4, 3, 1));
		placeInstr(rType(FnAnd, 5, 4, 3));
		placeInstr(rType(FnOr, 6, 5, 1));
		placeInstr(rType(FnSlt, 7, 6, 1));
		placeInstr(rType(FnSltu, 8, 7, 6));
		placeInstr(iType(OpAddi, 9, 8, 16'hFFFB));
		placeInstr(iType(OpAndi, 10, 9, 16'hF0F0));
		placeInstr(rType(FnAdd, 11, 2, 2));    // Wraps to zero
		v[1]  = 32'h0 | 32'h0000_1234;
		v[2]  = {16'h8000, 16'h0000};
		v[3]  = v[1] + v[2];
		v[4]  = v[3] - v[1];
		v[5]  = v[4] & v[3];
		v[6]  = v[5] | v[1];
		v[7]  = ($signed(v[6]) < $signed(v[1])) ? 32'd1 : 32'd0;
		v[8]  = (v[7] < v[6]) ? 32'd1 : 32'd0;
		v[9]  = v[8] + 32'hFFFF_FFFB;
		v[10] = v[9] & 32'h0000_F0F0;
		v[11] = v[2] + v[2];
		for (i = 1; i <= 11; i++)
			expectWrite(i, v[i], i - 1);
		releaseReset();
		compareTrace();
	endtask

	task automatic storeLoad();
		holdReset();
		placeInstr(iType(OpOri, 1, 0, 16'h0040));
		placeInstr(iType(OpOri, 2, 0, 16'h5A5A));
		placeInstr(iType(OpSw, 2, 1, 16'd8));
		placeInstr(iType(OpLw, 3, 1, 16'd8));
		placeInstr(rType(FnAdd, 4, 3, 2));    // Load-use stall
		expectWrite(1, 32'h0000_0040, 0);
		expectWrite(2, 32'h0000_5A5A, 1);
		expectWrite(3, 32'h0000_5A5A, 3);
		expectWrite(4, 32'h0000_5A5A + 32'h0000_5A5A, 4);
		releaseReset();
		compareTrace();
		checkValue("store count", 1, storeAddr.size());
		checkValue("dataAddr", 32'h0000_0040 + 32'd8, storeAddr[0]);
		checkValue("dataWdata", 32'h0000_5A5A, storeData[0]);
	endtask

	task automatic branchSlots();
		holdReset();
		placeInstr(iType(OpOri, 1, 0, 16'd5));
		placeInstr(iType(OpOri, 2, 0, 16'd5));
		placeInstr(iType(OpBeq, 2, 1, 16'd2));     // Taken
		placeInstr(iType(OpOri, 3, 0, 16'd1));
		placeInstr(iType(OpOri, 4, 0, 16'h99));    // Skipped
		placeInstr(iType(OpBeq, 0, 1, 16'd2));     // Not taken
		placeInstr(iType(OpOri, 5, 0, 16'd2));
		placeInstr(iType(OpOri, 6, 0, 16'd3));
		placeInstr(iType(OpBne, 6, 1, 16'd2));     // Taken
		placeInstr(iType(OpOri, 7, 0, 16'd4));
		placeInstr(iType(OpOri, 8, 0, 16'h77));    // Skipped
		placeInstr(iType(OpOri, 9, 0, 16'd6));
		expectWrite(1, 32'd5, 0);
		expectWrite(2, 32'd5, 1);
		expectWrite(3, 32'd1, 3);
		expectWrite(5, 32'd2, 6);
		expectWrite(6, 32'd3, 7);
		expectWrite(7, 32'd4, 9);
		expectWrite(9, 32'd6, 11);
		releaseReset();
		compareTrace();
	endtask

	task automatic jumpAndLink();
		holdReset();
		placeInstr(iType(OpOri, 1, 0, 16'd1));
		placeInstr(jalInstr(ResetPc + 32'd24));
		placeInstr(iType(OpOri, 2, 0, 16'd2));
		placeInstr(iType(OpOri, 3, 0, 16'd3));    // Return point
		placeInstr(iType(OpBeq, 0, 0, 16'd4));    // Over the subroutine
		placeInstr(32'h0000_0000);
		placeInstr(iType(OpOri, 4, 0, 16'd4));    // Subroutine
		placeInstr(rType(FnJr, 0, 31, 0));
		placeInstr(iType(OpOri, 5, 0, 16'd5));
		placeInstr(iType(OpOri, 6, 0, 16'd6));
		expectWrite(1, 32'd1, 0);
		expectWrite(31, ResetPc + 32'd4 + 32'd8, 1);
		expectWrite(2, 32'd2, 2);
		expectWrite(4, 32'd4, 6);
		expectWrite(5, 32'd5, 8);
		expectWrite(3, 32'd3, 3);
		expectWrite(6, 32'd6, 9);
		releaseReset();
		compareTrace();
	endtask

	task automatic zeroRegister();
		holdReset();
		placeInstr(iType(OpOri, 0, 0, 16'h55));
		placeInstr(iType(OpAddi, 0, 0, 16'd7));
		placeInstr(iType(OpAddi, 2, 0, 16'h11));
		placeInstr(rType(FnAdd, 3, 0, 2));
		placeInstr(rType(FnOr, 4, 0, 0));
		expectWrite(2, 32'd0 + 32'h11, 2);
		expectWrite(3, 32'd0 + 32'h11, 3);
		expectWrite(4, 32'd0, 4);
		releaseReset();
		compareTrace();
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		cycleCount = 0;
		clearMemories();
		aluChain();
		storeLoad();
		branchSlots();
		jumpAndLink();
		zeroRegister();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

/* mipsCore.f */
verilog/isaPkg.sv
verilog/hazardPkg.sv
verilog/regFile.sv
verilog/alu.sv
verilog/decodeUnit.sv
verilog/hazardUnit.sv
verilog/mipsCore.sv
tests/mipsCoreTb.sv

/* Bender.yml */
package:
  name: mipsCore

sources:
  - verilog/isaPkg.sv
  - verilog/hazardPkg.sv
  - verilog/regFile.sv
  - verilog/alu.sv
  - verilog/decodeUnit.sv
  - verilog/hazardUnit.sv
  - verilog/mipsCore.sv
  - target: test
    files:
      - tests/mipsCoreTb.sv
